/* mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// memory geometry shared by both ports
`define MEM_DW   32             // data word width
`define MEM_AW   10             // address width, depth 1024

// one enable per byte lane
`define MEM_BENW (`MEM_DW / 8)

`endif

/* mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

	// one data word, read data on both ports
	typedef logic [`MEM_DW-1:0] word_t;

	// host port request, presented once per cycle
	// no handshake, the RAM takes it on every edge
	typedef struct packed {
		logic                 we;        // write strobe
		logic [`MEM_BENW-1:0] byteena;   // lanes written when we is set
		logic [`MEM_AW-1:0]   addr;      // word address
		word_t                data;      // write data
	} host_req_t;

endpackage

/* dbg_pkg.sv */
`include "mem_settings.svh"

package dbg_pkg;

	// debug command opcodes
	typedef enum logic [1:0] {
		OP_SET_ADDR = 2'd0,   // load debug address
		OP_WRITE    = 2'd1,   // write word, step address
		OP_READ     = 2'd2,   // read word, step address
		OP_STATUS   = 2'd3    // report memory depth
	} dbg_op_e;

	// address view of the payload, address in the low bits
	typedef struct packed {
		logic [`MEM_DW-`MEM_AW-1:0] pad;
		logic [`MEM_AW-1:0]         addr;
	} dbg_addr_view_t;

	// payload word, meaning depends on the opcode
	typedef union packed {
		dbg_addr_view_t addr_view;   // OP_SET_ADDR
		mem_pkg::word_t data;        // OP_WRITE
	} dbg_payload_u;

	typedef struct packed {
		dbg_op_e      op;
		dbg_payload_u payload;
	} dbg_cmd_t;

	// response to OP_READ or OP_STATUS
	typedef struct packed {
		mem_pkg::word_t data;
		logic           is_status;   // set for status, clear for read data
	} dbg_rsp_t;

endpackage

/* dual_port_ram.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module dual_port_ram (
	input  logic                clk,
	// port A, host side
	input  mem_pkg::host_req_t  a_req_i,
	output mem_pkg::word_t      a_q_o,
	// port B, debug side
	input  logic [`MEM_AW-1:0]  b_addr_i,
	input  logic                b_we_i,
	input  mem_pkg::word_t      b_data_i,
	output mem_pkg::word_t      b_q_o
);

	localparam int unsigned DEPTH = 1 << `MEM_AW;

	mem_pkg::word_t mem [DEPTH];

	// both ports in one process on the single clock
	// same-address collisions between ports are undefined
	always_ff @(posedge clk) begin
		// read-first, q sees the word before this edge's write
		a_q_o <= mem[a_req_i.addr];
		b_q_o <= mem[b_addr_i];

		// port A writes only the enabled byte lanes
		if (a_req_i.we) begin
			for (int i = 0; i < `MEM_BENW; i++) begin
				if (a_req_i.byteena[i]) begin
					mem[a_req_i.addr][i*8 +: 8] <= a_req_i.data[i*8 +: 8];
				end
			end
		end

		if (b_we_i) begin
			mem[b_addr_i] <= b_data_i;   // whole word
		end
	end

endmodule

/* dbg_addr_counter.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module dbg_addr_counter (
	input  logic                clk,
	input  logic                reset_i,
	input  logic                load_i,
	input  logic [`MEM_AW-1:0]  load_addr_i,
	input  logic                step_i,
	output logic [`MEM_AW-1:0]  addr_o
);

	logic [`MEM_AW-1:0] addr_q;

	// load wins over step
	always_ff @(posedge clk) begin
		if (reset_i) begin
			addr_q <= '0;
		end else if (load_i) begin
			addr_q <= load_addr_i;
		end else if (step_i) begin
			addr_q <= addr_q + 1'b1;   // wraps to 0 past the top of memory
		end
	end

	assign addr_o = addr_q;

endmodule

/* dbg_cmd_fsm.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module dbg_cmd_fsm (
	input  logic                clk,
	input  logic                reset_i,
	// command stream
	input  dbg_pkg::dbg_cmd_t   cmd_i,
	input  logic                cmd_valid_i,
	output logic                cmd_ready_o,
	// response stream
	output dbg_pkg::dbg_rsp_t   rsp_o,
	output logic                rsp_valid_o,
	input  logic                rsp_ready_i,
	// address counter control
	output logic                addr_load_o,
	output logic [`MEM_AW-1:0]  load_addr_o,
	output logic                addr_step_o,
	// RAM port B
	output logic                ram_we_o,
	output mem_pkg::word_t      ram_data_o,
	input  mem_pkg::word_t      ram_q_i
);

	localparam int unsigned MEM_DEPTH = 1 << `MEM_AW;

	typedef enum logic [1:0] {
		ST_IDLE,    // waiting for a command
		ST_WRITE,   // port B write in flight
		ST_READ,    // port B read address presented
		ST_RESP     // response pending or being filled
	} state_e;

	state_e            state_q;
	state_e            state_d;
	logic              cmd_ready_q;
	logic              rsp_valid_q;
	dbg_pkg::dbg_rsp_t rsp_q;
	mem_pkg::word_t    wdata_q;

	logic accept;
	logic rsp_taken;
	logic rd_fill;
	logic is_set_addr;
	logic is_write;
	logic is_read;
	logic is_status;

	assign accept    = cmd_valid_i && cmd_ready_q;
	assign rsp_taken = rsp_valid_q && rsp_ready_i;

	// in ST_RESP without valid, RAM data is captured at this edge
	assign rd_fill = (state_q == ST_RESP) && !rsp_valid_q;

	assign is_set_addr = (cmd_i.op == dbg_pkg::OP_SET_ADDR);
	assign is_write    = (cmd_i.op == dbg_pkg::OP_WRITE);
	assign is_read     = (cmd_i.op == dbg_pkg::OP_READ);
	assign is_status   = (cmd_i.op == dbg_pkg::OP_STATUS);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (accept) begin
					if (is_write) begin
						state_d = ST_WRITE;
					end else if (is_read) begin
						state_d = ST_READ;
					end else if (is_status) begin
						state_d = ST_RESP;
					end
					// set address finishes in idle
				end
			end
			ST_WRITE: state_d = ST_IDLE;
			ST_READ:  state_d = ST_RESP;
			ST_RESP: begin
				if (rsp_taken) begin
					state_d = ST_IDLE;
				end
			end
			default:  state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q     <= ST_IDLE;
			cmd_ready_q <= 1'b0;   // rises on the first edge out of reset
			rsp_valid_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			cmd_ready_q <= (state_d == ST_IDLE);
			if (accept && is_status) begin
				rsp_valid_q <= 1'b1;
			end else if (rd_fill) begin
				rsp_valid_q <= 1'b1;
			end else if (rsp_taken) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (accept && is_write) begin
			wdata_q <= cmd_i.payload.data;
		end
		if (accept && is_status) begin
			rsp_q.data      <= mem_pkg::word_t'(MEM_DEPTH);
			rsp_q.is_status <= 1'b1;
		end else if (rd_fill) begin
			rsp_q.data      <= ram_q_i;   // read issued in ST_READ
			rsp_q.is_status <= 1'b0;
		end
	end

	// counter load straight off the accepted command
	assign addr_load_o = accept && is_set_addr;
	assign load_addr_o = cmd_i.payload.addr_view.addr;

	// step with the write, and with the read capture
	assign addr_step_o = (state_q == ST_WRITE) || rd_fill;

	assign ram_we_o    = (state_q == ST_WRITE);
	assign ram_data_o  = wdata_q;

	assign cmd_ready_o = cmd_ready_q;
	assign rsp_o       = rsp_q;
	assign rsp_valid_o = rsp_valid_q;

endmodule

/* dbg_port_ram.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module dbg_port_ram (
	input  logic                clk,
	input  logic                reset_i,
	// host port, always ready
	input  mem_pkg::host_req_t  host_req_i,
	output mem_pkg::word_t      host_q_o,
	// debug command stream
	input  dbg_pkg::dbg_cmd_t   dbg_cmd_i,
	input  logic                dbg_cmd_valid_i,
	output logic                dbg_cmd_ready_o,
	// debug response stream
	output dbg_pkg::dbg_rsp_t   dbg_rsp_o,
	output logic                dbg_rsp_valid_o,
	input  logic                dbg_rsp_ready_i
);

	logic [`MEM_AW-1:0] dbg_addr;      // current debug address
	logic               addr_load;
	logic [`MEM_AW-1:0] load_addr;
	logic               addr_step;
	logic               ram_we;
	mem_pkg::word_t     ram_wdata;
	mem_pkg::word_t     ram_q;

	// storage, host on A and debug on B
	dual_port_ram u_ram (
		.clk      (clk),
		.a_req_i  (host_req_i),
		.a_q_o    (host_q_o),
		.b_addr_i (dbg_addr),
		.b_we_i   (ram_we),
		.b_data_i (ram_wdata),
		.b_q_o    (ram_q)
	);

	dbg_addr_counter u_addr_counter (
		.clk         (clk),
		.reset_i     (reset_i),
		.load_i      (addr_load),
		.load_addr_i (load_addr),
		.step_i      (addr_step),
		.addr_o      (dbg_addr)
	);

	// command decode and port B sequencing
	dbg_cmd_fsm u_cmd_fsm (
		.clk         (clk),
		.reset_i     (reset_i),
		.cmd_i       (dbg_cmd_i),
		.cmd_valid_i (dbg_cmd_valid_i),
		.cmd_ready_o (dbg_cmd_ready_o),
		.rsp_o       (dbg_rsp_o),
		.rsp_valid_o (dbg_rsp_valid_o),
		.rsp_ready_i (dbg_rsp_ready_i),
		.addr_load_o (addr_load),
		.load_addr_o (load_addr),
		.addr_step_o (addr_step),
		.ram_we_o    (ram_we),
		.ram_data_o  (ram_wdata),
		.ram_q_i     (ram_q)
	);

endmodule

/* tb_dbg_port_ram.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"

module tb_dbg_port_ram;

	localparam int DEPTH       = 1 << `MEM_AW;
	localparam int CYCLE_LIMIT = 200;   // per-wait limit in clock cycles

	typedef logic [`MEM_AW-1:0] addr_t;

	logic               clk = 1'b0;
	logic               reset_i;
	mem_pkg::host_req_t host_req_i;
	mem_pkg::word_t     host_q_o;
	dbg_pkg::dbg_cmd_t  dbg_cmd_i;
	logic               dbg_cmd_valid_i;
	logic               dbg_cmd_ready_o;
	dbg_pkg::dbg_rsp_t  dbg_rsp_o;
	logic               dbg_rsp_valid_o;
	logic               dbg_rsp_ready_i;

	int                 seed   = 96282;
	mem_pkg::word_t     model [DEPTH];    // mirror of the RAM contents
	addr_t              dbg_addr_model;   // where the debug counter should be
	logic               host_rd_active;   // checked host read on the port
	mem_pkg::word_t     exp_host_q [$];
	dbg_pkg::dbg_rsp_t  exp_rsp_q [$];

	dbg_port_ram u_dbg_port_ram (
		.clk             (clk),
		.reset_i         (reset_i),
		.host_req_i      (host_req_i),
		.host_q_o        (host_q_o),
		.dbg_cmd_i       (dbg_cmd_i),
		.dbg_cmd_valid_i (dbg_cmd_valid_i),
		.dbg_cmd_ready_o (dbg_cmd_ready_o),
		.dbg_rsp_o       (dbg_rsp_o),
		.dbg_rsp_valid_o (dbg_rsp_valid_o),
		.dbg_rsp_ready_i (dbg_rsp_ready_i)
	);

	always #10 clk = ~clk;   // 20 ns period

	// word after a write that only touches the enabled byte lanes
	function automatic mem_pkg::word_t merge_bytes(
		input mem_pkg::word_t       old_w,
		input mem_pkg::word_t       new_w,
		input logic [`MEM_BENW-1:0] be
	);
		mem_pkg::word_t mask;
		mask = '0;
		for (int i = 0; i < `MEM_BENW; i++) begin
			if (be[i]) begin
				mask[i*8 +: 8] = 8'hff;
			end
		end
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic mem_pkg::word_t expected_depth();
		return mem_pkg::word_t'(2 ** `MEM_AW);
	endfunction

	// start-up contents, every address bit shows up twice
	function automatic mem_pkg::word_t fill_word(input addr_t a);
		return {6'h2a, a, 6'h15, ~a};
	endfunction

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(
		input string          name,
		input mem_pkg::word_t exp,
		input mem_pkg::word_t act
	);
		if (act !== exp) begin
			stop_with_error($sformatf("mismatch at %0t ns: %s expected %h actual %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_rsp(input dbg_pkg::dbg_rsp_t exp, input dbg_pkg::dbg_rsp_t act);
		if (act !== exp) begin
			stop_with_error($sformatf(
				"mismatch at %0t ns: dbg_rsp_o expected %h/%b actual %h/%b",
				$time, exp.data, exp.is_status, act.data, act.is_status));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_error($sformatf("mismatch at %0t ns: %s expected %b actual %b",
				$time, name, exp, act));
		end
	endtask

	// compares host read data and debug responses at the falling edge
	initial begin : compare_proc
		logic host_chk;
		logic rsp_taken;
		logic rsp_seen_valid;
		rsp_seen_valid = 1'b0;
		forever begin
			@(posedge clk);
			host_chk  = host_rd_active;
			rsp_taken = rsp_seen_valid && dbg_rsp_ready_i;   // handshake at this edge
			@(negedge clk);
			if (host_chk) begin
				check_word("host_q_o", exp_host_q.pop_front(), host_q_o);
			end
			if (rsp_taken) begin
				exp_rsp_q.delete(0);
			end else if (rsp_seen_valid) begin
				check_flag("dbg_rsp_valid_o", 1'b1, dbg_rsp_valid_o);   // held until taken
			end
			if (dbg_rsp_valid_o === 1'b1) begin
				if (exp_rsp_q.size() == 0) begin
					stop_with_error("debug response valid with no command outstanding");
				end
				check_rsp(exp_rsp_q[0], dbg_rsp_o);
				check_flag("dbg_cmd_ready_o", 1'b0, dbg_cmd_ready_o);
			end
			rsp_seen_valid = (dbg_rsp_valid_o === 1'b1);
		end
	end

	task automatic park_host_port();
		host_req_i.we      = 1'b0;
		host_req_i.byteena = '0;
		host_rd_active     = 1'b0;
	endtask

	task automatic write_host_word(
		input addr_t                a,
		input mem_pkg::word_t       d,
		input logic [`MEM_BENW-1:0] be
	);
		host_req_i.we      = 1'b1;
		host_req_i.byteena = be;
		host_req_i.addr    = a;
		host_req_i.data    = d;
		host_rd_active     = 1'b0;
		model[a] = merge_bytes(model[a], d, be);
		@(negedge clk);
	endtask

	task automatic read_host_word(input addr_t a);
		host_req_i.we   = 1'b0;
		host_req_i.addr = a;
		host_rd_active  = 1'b1;
		exp_host_q.push_back(model[a]);
		@(negedge clk);
	endtask

	task automatic wait_cmd_ready();
		int waited;
		waited = 0;
		while (dbg_cmd_ready_o !== 1'b1) begin
			if (waited == CYCLE_LIMIT) begin
				stop_with_error("timeout: debug command ready never came back");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// ready is registered, so the value seen here holds at the next edge
	task automatic send_cmd(input dbg_pkg::dbg_cmd_t cmd);
		int waited;
		waited = 0;
		dbg_cmd_i       = cmd;
		dbg_cmd_valid_i = 1'b1;
		while (dbg_cmd_ready_o !== 1'b1) begin
			if (waited == CYCLE_LIMIT) begin
				stop_with_error("timeout: debug command was never accepted");
			end
			@(negedge clk);
			waited++;
		end
		@(negedge clk);   // transfer on the edge in between
		dbg_cmd_valid_i = 1'b0;
	endtask

	task automatic take_rsp(input logic stall);
		int          waited;
		logic        done;
		logic [31:0] rnd;
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			if (waited == CYCLE_LIMIT) begin
				stop_with_error("timeout: debug response handshake never completed");
			end
			if (stall) begin
				rnd = $random(seed);
				dbg_rsp_ready_i = (rnd[1:0] == 2'b00);   // about one cycle in four
			end else begin
				dbg_rsp_ready_i = 1'b1;
			end
			done = (dbg_rsp_valid_o === 1'b1) && dbg_rsp_ready_i;
			@(negedge clk);
			waited++;
		end
		dbg_rsp_ready_i = 1'b0;
	endtask

	task automatic load_debug_addr(input addr_t a);
		dbg_pkg::dbg_cmd_t cmd;
		cmd.op                     = dbg_pkg::OP_SET_ADDR;
		cmd.payload                = '0;
		cmd.payload.addr_view.addr = a;
		send_cmd(cmd);
		dbg_addr_model = a;
	endtask

	task automatic write_debug_word(input mem_pkg::word_t d);
		dbg_pkg::dbg_cmd_t cmd;
		cmd.op           = dbg_pkg::OP_WRITE;
		cmd.payload.data = d;
		send_cmd(cmd);
		model[dbg_addr_model] = d;
		dbg_addr_model = dbg_addr_model + 1'b1;   // wraps with the address width
	endtask

	task automatic read_debug_word(input logic stall);
		dbg_pkg::dbg_cmd_t cmd;
		dbg_pkg::dbg_rsp_t exp;
		exp.data      = model[dbg_addr_model];
		exp.is_status = 1'b0;
		exp_rsp_q.push_back(exp);
		cmd.op      = dbg_pkg::OP_READ;
		cmd.payload = '0;
		send_cmd(cmd);
		dbg_addr_model = dbg_addr_model + 1'b1;
		take_rsp(stall);
	endtask

	task automatic query_status(input logic stall);
		dbg_pkg::dbg_cmd_t cmd;
		dbg_pkg::dbg_rsp_t exp;
		exp.data      = expected_depth();
		exp.is_status = 1'b1;
		exp_rsp_q.push_back(exp);
		cmd.op      = dbg_pkg::OP_STATUS;
		cmd.payload = '0;
		send_cmd(cmd);
		take_rsp(stall);
	endtask

	task automatic preload_memory();
		for (int i = 0; i < DEPTH; i++) begin
			write_host_word(addr_t'(i), fill_word(addr_t'(i)), '1);
		end
		park_host_port();
	endtask

	task automatic host_byte_writes();
		addr_t          addrs [16];
		logic [31:0]    rnd;
		mem_pkg::word_t d;
		for (int i = 0; i < 16; i++) begin
			rnd      = $random(seed);
			addrs[i] = rnd[`MEM_AW-1:0];
			d        = $random(seed);
			rnd      = $random(seed);
			write_host_word(addrs[i], d, rnd[`MEM_BENW-1:0]);
		end
		for (int i = 0; i < 16; i++) begin
			read_host_word(addrs[i]);
		end
		park_host_port();
	endtask

	task automatic debug_burst_load();
		logic [31:0]    rnd;
		addr_t          base;
		mem_pkg::word_t d;
		rnd  = $random(seed);
		base = rnd[`MEM_AW-1:0];
		load_debug_addr(base);
		for (int i = 0; i < 8; i++) begin
			d = $random(seed);
			write_debug_word(d);
		end
		wait_cmd_ready();   // last write has landed
		for (int i = 0; i < 8; i++) begin
			read_host_word(base + addr_t'(i));
		end
		park_host_port();
	endtask

	task automatic debug_wrap_readback();
		addr_t          a;
		mem_pkg::word_t d;
		a = addr_t'(DEPTH - 3);
		for (int i = 0; i < 6; i++) begin
			d = $random(seed);
			write_host_word(a, d, '1);
			a = a + 1'b1;
		end
		park_host_port();
		load_debug_addr(addr_t'(DEPTH - 3));
		for (int i = 0; i < 5; i++) begin
			read_debug_word(1'b0);   // crosses the top into 0 and 1
		end
	endtask

	task automatic status_keeps_address();
		logic [31:0] rnd;
		rnd = $random(seed);
		load_debug_addr(rnd[`MEM_AW-1:0]);
		read_debug_word(1'b0);
		query_status(1'b0);
		read_debug_word(1'b0);   // counter must not have moved
	endtask

	task automatic readback_under_stall();
		logic [31:0] rnd;
		rnd = $random(seed);
		load_debug_addr(rnd[`MEM_AW-1:0]);
		for (int i = 0; i < 12; i++) begin
			if (i == 5) begin
				query_status(1'b1);
			end
			read_debug_word(1'b1);
		end
	endtask

	task automatic drain_checks();
		int waited;
		waited = 0;
		while (exp_host_q.size() != 0 || exp_rsp_q.size() != 0) begin
			if (waited == CYCLE_LIMIT) begin
				stop_with_error("timeout: expected results were never compared");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	initial begin : main_seq
		reset_i         = 1'b1;
		host_req_i      = '0;
		dbg_cmd_i       = '0;
		dbg_cmd_valid_i = 1'b0;
		dbg_rsp_ready_i = 1'b0;
		host_rd_active  = 1'b0;
		dbg_addr_model  = '0;

		repeat (8) @(posedge clk);
		@(negedge clk);
		check_flag("dbg_cmd_ready_o", 1'b0, dbg_cmd_ready_o);   // quiet in reset
		check_flag("dbg_rsp_valid_o", 1'b0, dbg_rsp_valid_o);
		reset_i = 1'b0;
		@(negedge clk);
		check_flag("dbg_cmd_ready_o", 1'b1, dbg_cmd_ready_o);   // first cycle after reset

		preload_memory();
		read_debug_word(1'b0);   // counter comes out of reset at 0
		host_byte_writes();
		debug_burst_load();
		debug_wrap_readback();
		status_keeps_address();
		readback_under_stall();
		drain_checks();

		$display("all tests passed");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
mem_pkg.sv
dbg_pkg.sv
dual_port_ram.sv
dbg_addr_counter.sv
dbg_cmd_fsm.sv
dbg_port_ram.sv
tb_dbg_port_ram.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_dbg_port_ram

verilator --binary --timing -f project.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
